// File: Bender.yml
package:
  name: tg_driver

sources:
  - files:
      - rtl/tg_seq_pkg.sv
      - rtl/cfg_user_gate.sv
      - rtl/stage_sequencer.sv
      - rtl/cfg_stage_writer.sv
      - rtl/cfg_master_mux.sv
      - rtl/tg_driver_top.sv
  - target: simulation
    files:
      - tb/tb_clock_gen.sv
      - tb/tb_driver_top.sv

// File: rtl/cfg_master_mux.sv
////////////////////////////////////////////////////////////
// Combinational, the owner follows the stage alone
////////////////////////////////////////////////////////////

module cfg_master_mux #(
   parameter int CFG_ADDR_W = tg_seq_pkg::CFG_ADDR_W,
   parameter int CFG_DATA_W = tg_seq_pkg::CFG_DATA_W
) (
   input  tg_seq_pkg::stage_t    stage,
   input  logic [CFG_ADDR_W-1:0] user_address,
   input  logic [CFG_DATA_W-1:0] user_writedata,
   input  logic                  user_write,
   input  logic                  user_read,
   input  logic [CFG_ADDR_W-1:0] single_address,
   input  logic [CFG_DATA_W-1:0] single_writedata,
   input  logic                  single_write,
   input  logic [CFG_ADDR_W-1:0] block_address,
   input  logic [CFG_DATA_W-1:0] block_writedata,
   input  logic                  block_write,
   input  logic [CFG_DATA_W-1:0] cfg_readdata,
   input  logic                  cfg_readdatavalid,
   output logic [CFG_ADDR_W-1:0] cfg_address,
   output logic [CFG_DATA_W-1:0] cfg_writedata,
   output logic                  cfg_write,
   output logic                  cfg_read,
   output logic [CFG_DATA_W-1:0] user_readdata,
   output logic                  user_readdatavalid
);

   import tg_seq_pkg::*;

   logic user_owns;
   // User writes held off while a user test runs
   logic write_stall;

   assign user_owns   = (stage == ST_WAIT_USER) || (stage == ST_INIT_USER) ||
                        (stage == ST_USER_LOOP) || (stage == ST_DONE);
   assign write_stall = (stage == ST_INIT_USER) || (stage == ST_USER_LOOP);

   always_comb begin
      cfg_address   = '0;
      cfg_writedata = '0;
      cfg_write     = 1'b0;
      cfg_read      = 1'b0;
      if (user_owns) begin
         cfg_address   = user_address;
         cfg_writedata = user_writedata;
         cfg_write     = user_write && !write_stall;
         cfg_read      = user_read;
      end else if (stage == ST_SINGLE_RW) begin
         cfg_address   = single_address;
         cfg_writedata = single_writedata;
         cfg_write     = single_write;
      end else if (stage == ST_BLOCK_RW) begin
         cfg_address   = block_address;
         cfg_writedata = block_writedata;
         cfg_write     = block_write;
      end
   end

   // Read return only to the user port
   assign user_readdata      = user_owns ? cfg_readdata : '0;
   assign user_readdatavalid = user_owns && cfg_readdatavalid;

endmodule

// File: rtl/cfg_stage_writer.sv
////////////////////////////////////////////////////////////
// Write only, no read-back of the generator registers
// Leaving MY_STAGE early aborts the program
////////////////////////////////////////////////////////////

module cfg_stage_writer #(
   parameter int                 CFG_ADDR_W = tg_seq_pkg::CFG_ADDR_W,
   parameter int                 CFG_DATA_W = tg_seq_pkg::CFG_DATA_W,
   parameter int                 BURST_LEN  = 1,
   parameter tg_seq_pkg::stage_t MY_STAGE   = tg_seq_pkg::ST_SINGLE_RW
) (
   input  logic                  clk,
   input  logic                  rst,
   input  tg_seq_pkg::stage_t    stage,
   input  logic                  cfg_waitrequest,
   input  logic                  tg_test_complete,
   output logic [CFG_ADDR_W-1:0] wr_address,
   output logic [CFG_DATA_W-1:0] wr_writedata,
   output logic                  wr_write,
   output logic                  complete
);

   import tg_seq_pkg::*;

   // Index of the start write, the last of the program
   localparam logic [1:0] LAST_IDX = 2'd2;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_WRITE,
      WR_WAIT,
      WR_DONE
   } wr_state_t;

   wr_state_t  state;
   logic [1:0] idx;
   logic       in_stage;

   assign in_stage = (stage == MY_STAGE);

   always_ff @(posedge clk) begin
      if (rst) begin
         state <= WR_IDLE;
         idx   <= '0;
      end else begin
         case (state)
            WR_IDLE: begin
               if (in_stage) begin
                  state <= WR_WRITE;
                  idx   <= '0;
               end
            end
            WR_WRITE: begin
               if (!in_stage) begin
                  state <= WR_IDLE;
               end else if (!cfg_waitrequest) begin
                  if (idx == LAST_IDX) begin
                     state <= WR_WAIT;
                  end else begin
                     idx <= idx + 1'b1;
                  end
               end
            end
            // Generator is running the test
            WR_WAIT: begin
               if (!in_stage) begin
                  state <= WR_IDLE;
               end else if (tg_test_complete) begin
                  state <= WR_DONE;
               end
            end
            default: begin
               state <= WR_IDLE;
            end
         endcase
      end
   end

   // Write program
   always_comb begin
      case (idx)
         2'd0: begin
            wr_address   = CFG_ADDR_W'(REG_LOOP_COUNT);
            wr_writedata = CFG_DATA_W'(1);
         end
         2'd1: begin
            wr_address   = CFG_ADDR_W'(REG_BURST_LENGTH);
            wr_writedata = CFG_DATA_W'(BURST_LEN);
         end
         default: begin
            wr_address   = CFG_ADDR_W'(REG_START);
            wr_writedata = CFG_DATA_W'(1);
         end
      endcase
   end

   assign wr_write = (state == WR_WRITE);
   assign complete = (state == WR_DONE);

endmodule

// File: rtl/cfg_user_gate.sv
////////////////////////////////////////////////////////////
// Purely combinational, the user must hold strobe and payload
// until user_waitrequest is low
////////////////////////////////////////////////////////////

module cfg_user_gate #(
   parameter int CFG_ADDR_W = tg_seq_pkg::CFG_ADDR_W
) (
   input  tg_seq_pkg::stage_t    stage,
   input  logic [CFG_ADDR_W-1:0] user_address,
   input  logic                  user_write,
   output logic                  user_waitrequest,
   output logic                  user_cfg_start
);

   import tg_seq_pkg::*;

   // Any access allowed
   logic user_open;
   // Reads allowed, writes stalled while a user test runs
   logic user_read_only;

   assign user_open      = (stage == ST_WAIT_USER) || (stage == ST_DONE);
   assign user_read_only = (stage == ST_INIT_USER) || (stage == ST_USER_LOOP);

   always_comb begin
      if (user_open) begin
         user_waitrequest = 1'b0;
      end else if (user_read_only) begin
         user_waitrequest = user_write;
      end else begin
         // Default pattern owns the bus
         user_waitrequest = 1'b1;
      end
   end

   // Start write seen in the cycle it is accepted
   assign user_cfg_start = !user_waitrequest && user_write &&
                           (user_address == CFG_ADDR_W'(REG_START));

endmodule

// File: rtl/stage_sequencer.sv
////////////////////////////////////////////////////////////
// NUM_LOOPS must be at least 1
// A timeout in a default stage skips the rest of the pattern
////////////////////////////////////////////////////////////

module stage_sequencer #(
   parameter int NUM_LOOPS = 2
) (
   input  logic               clk,
   input  logic               rst,
   input  logic               ctrl_ready,
   input  logic               restart_default_traffic,
   input  logic               timeout,
   input  logic               tg_test_complete,
   input  logic               single_complete,
   input  logic               block_complete,
   input  logic               user_cfg_start,
   output tg_seq_pkg::stage_t stage,
   output logic               rst_config,
   output logic               at_default_stage,
   output logic               at_wait_user_stage,
   output logic               at_done_stage
);

   import tg_seq_pkg::*;

   // Wide enough to hold NUM_LOOPS itself
   localparam int CNT_W = $clog2(NUM_LOOPS + 1);

   stage_t           stage_next;
   logic [CNT_W-1:0] loop_cnt;
   logic             more_loops;

   ////////////////////////////////////////////////////////////
   // Stage register
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst) begin
         stage <= ST_INIT;
      end else begin
         stage <= stage_next;
      end
   end

   always_comb begin
      stage_next = stage;
      case (stage)
         ST_INIT: begin
            if (ctrl_ready) begin
               stage_next = ST_SINGLE_RW;
            end
         end
         ST_SINGLE_RW: begin
            if (timeout) begin
               stage_next = ST_RESET_CONFIG;
            end else if (single_complete) begin
               stage_next = ST_BLOCK_RW;
            end
         end
         ST_BLOCK_RW: begin
            if (timeout) begin
               stage_next = ST_RESET_CONFIG;
            end else if (block_complete) begin
               stage_next = ST_DONE_DEFAULT;
            end
         end
         ST_DONE_DEFAULT: begin
            stage_next = more_loops ? ST_INIT : ST_RESET_CONFIG;
         end
         // Single cycle config reset pulse
         ST_RESET_CONFIG: begin
            stage_next = ST_WAIT_USER;
         end
         ST_WAIT_USER, ST_DONE: begin
            if (restart_default_traffic) begin
               stage_next = ST_INIT;
            end else if (user_cfg_start) begin
               stage_next = ST_INIT_USER;
            end
         end
         ST_INIT_USER: begin
            stage_next = ST_USER_LOOP;
         end
         ST_USER_LOOP: begin
            if (tg_test_complete || timeout) begin
               stage_next = ST_DONE;
            end
         end
         default: begin
            stage_next = ST_INIT;
         end
      endcase
   end

   ////////////////////////////////////////////////////////////
   // Default pattern loop counter
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk) begin
      if (rst || restart_default_traffic || (stage == ST_DONE)) begin
         loop_cnt <= '0;
      end else if (stage == ST_DONE_DEFAULT) begin
         loop_cnt <= loop_cnt + 1'b1;
      end
   end

   // Counter still shows the passes before the current one
   assign more_loops = (loop_cnt != CNT_W'(NUM_LOOPS - 1));

   ////////////////////////////////////////////////////////////
   // Status decode
   ////////////////////////////////////////////////////////////

   assign rst_config = (stage == ST_RESET_CONFIG);

   assign at_default_stage = (stage == ST_INIT) || (stage == ST_SINGLE_RW) ||
                             (stage == ST_BLOCK_RW) || (stage == ST_DONE_DEFAULT) ||
                             (stage == ST_WAIT_USER);

   // Hidden in the cycle a user test is launched
   assign at_wait_user_stage = (stage == ST_WAIT_USER) && !user_cfg_start;
   assign at_done_stage      = (stage == ST_DONE) && !user_cfg_start;

endmodule

// File: rtl/tg_driver_top.sv
////////////////////////////////////////////////////////////
// Default pattern runs once ctrl_ready is seen after reset
// The user port reaches the generator only after the pattern
////////////////////////////////////////////////////////////

module tg_driver_top #(
   parameter int NUM_LOOPS  = 2,
   parameter int BLOCK_LEN  = 16,
   parameter int CFG_ADDR_W = tg_seq_pkg::CFG_ADDR_W,
   parameter int CFG_DATA_W = tg_seq_pkg::CFG_DATA_W
) (
   input  logic                  clk,
   input  logic                  rst,
   // Generator status
   input  logic                  ctrl_ready,
   input  logic                  restart_default_traffic,
   input  logic                  tg_test_complete,
   input  logic                  timeout,
   // User port
   input  logic [CFG_ADDR_W-1:0] user_address,
   input  logic [CFG_DATA_W-1:0] user_writedata,
   input  logic                  user_write,
   input  logic                  user_read,
   output logic                  user_waitrequest,
   output logic [CFG_DATA_W-1:0] user_readdata,
   output logic                  user_readdatavalid,
   // Config master
   output logic [CFG_ADDR_W-1:0] cfg_address,
   output logic [CFG_DATA_W-1:0] cfg_writedata,
   output logic                  cfg_write,
   output logic                  cfg_read,
   input  logic                  cfg_waitrequest,
   input  logic [CFG_DATA_W-1:0] cfg_readdata,
   input  logic                  cfg_readdatavalid,
   // Status
   output logic                  rst_config,
   output logic                  user_cfg_start,
   output logic                  at_default_stage,
   output logic                  at_wait_user_stage,
   output logic                  at_done_stage
);

   import tg_seq_pkg::*;

   stage_t                stage;
   logic [CFG_ADDR_W-1:0] single_address;
   logic [CFG_DATA_W-1:0] single_writedata;
   logic                  single_write;
   logic                  single_complete;
   logic [CFG_ADDR_W-1:0] block_address;
   logic [CFG_DATA_W-1:0] block_writedata;
   logic                  block_write;
   logic                  block_complete;

   cfg_user_gate #(
      .CFG_ADDR_W (CFG_ADDR_W)
   ) u_user_gate (
      .stage            (stage),
      .user_address     (user_address),
      .user_write       (user_write),
      .user_waitrequest (user_waitrequest),
      .user_cfg_start   (user_cfg_start)
   );

   stage_sequencer #(
      .NUM_LOOPS (NUM_LOOPS)
   ) u_sequencer (
      .clk                     (clk),
      .rst                     (rst),
      .ctrl_ready              (ctrl_ready),
      .restart_default_traffic (restart_default_traffic),
      .timeout                 (timeout),
      .tg_test_complete        (tg_test_complete),
      .single_complete         (single_complete),
      .block_complete          (block_complete),
      .user_cfg_start          (user_cfg_start),
      .stage                   (stage),
      .rst_config              (rst_config),
      .at_default_stage        (at_default_stage),
      .at_wait_user_stage      (at_wait_user_stage),
      .at_done_stage           (at_done_stage)
   );

   ////////////////////////////////////////////////////////////
   // Test stages
   ////////////////////////////////////////////////////////////

   cfg_stage_writer #(
      .CFG_ADDR_W (CFG_ADDR_W),
      .CFG_DATA_W (CFG_DATA_W),
      .BURST_LEN  (1),
      .MY_STAGE   (ST_SINGLE_RW)
   ) single_stage (
      .clk              (clk),
      .rst              (rst),
      .stage            (stage),
      .cfg_waitrequest  (cfg_waitrequest),
      .tg_test_complete (tg_test_complete),
      .wr_address       (single_address),
      .wr_writedata     (single_writedata),
      .wr_write         (single_write),
      .complete         (single_complete)
   );

   cfg_stage_writer #(
      .CFG_ADDR_W (CFG_ADDR_W),
      .CFG_DATA_W (CFG_DATA_W),
      .BURST_LEN  (BLOCK_LEN),
      .MY_STAGE   (ST_BLOCK_RW)
   ) block_stage (
      .clk              (clk),
      .rst              (rst),
      .stage            (stage),
      .cfg_waitrequest  (cfg_waitrequest),
      .tg_test_complete (tg_test_complete),
      .wr_address       (block_address),
      .wr_writedata     (block_writedata),
      .wr_write         (block_write),
      .complete         (block_complete)
   );

   cfg_master_mux #(
      .CFG_ADDR_W (CFG_ADDR_W),
      .CFG_DATA_W (CFG_DATA_W)
   ) u_master_mux (
      .stage              (stage),
      .user_address       (user_address),
      .user_writedata     (user_writedata),
      .user_write         (user_write),
      .user_read          (user_read),
      .single_address     (single_address),
      .single_writedata   (single_writedata),
      .single_write       (single_write),
      .block_address      (block_address),
      .block_writedata    (block_writedata),
      .block_write        (block_write),
      .cfg_readdata       (cfg_readdata),
      .cfg_readdatavalid  (cfg_readdatavalid),
      .cfg_address        (cfg_address),
      .cfg_writedata      (cfg_writedata),
      .cfg_write          (cfg_write),
      .cfg_read           (cfg_read),
      .user_readdata      (user_readdata),
      .user_readdatavalid (user_readdatavalid)
   );

endmodule

// File: rtl/tg_seq_pkg.sv
////////////////////////////////////////////////////////////
// Register map covers only the start, loop and burst registers
// Stage encoding fits one 4-bit word
////////////////////////////////////////////////////////////

package tg_seq_pkg;

   ////////////////////////////////////////////////////////////
   // Config bus widths
   ////////////////////////////////////////////////////////////

   // Defaults only, the top level passes the real values down
   localparam int CFG_ADDR_W = 10;
   localparam int CFG_DATA_W = 32;

   ////////////////////////////////////////////////////////////
   // Generator register addresses
   ////////////////////////////////////////////////////////////

   // Writing 1 launches a test
   localparam int unsigned REG_START        = 0;
   // Number of passes the generator runs per test
   localparam int unsigned REG_LOOP_COUNT   = 1;
   // Words per burst
   localparam int unsigned REG_BURST_LENGTH = 2;

   ////////////////////////////////////////////////////////////
   // Sequencer stages
   ////////////////////////////////////////////////////////////

   typedef enum logic [3:0] {
      // Default pattern side
      ST_INIT         = 4'd0,
      ST_SINGLE_RW    = 4'd1,
      ST_BLOCK_RW     = 4'd2,
      ST_DONE_DEFAULT = 4'd3,
      ST_RESET_CONFIG = 4'd4,
      // User side
      ST_WAIT_USER    = 4'd5,
      ST_INIT_USER    = 4'd6,
      ST_USER_LOOP    = 4'd7,
      ST_DONE         = 4'd8
   } stage_t;

endpackage

// File: sim.f
rtl/tg_seq_pkg.sv
rtl/cfg_user_gate.sv
rtl/stage_sequencer.sv
rtl/cfg_stage_writer.sv
rtl/cfg_master_mux.sv
rtl/tg_driver_top.sv
tb/tb_clock_gen.sv
tb/tb_driver_top.sv

// File: tb/tb_clock_gen.sv
////////////////////////////////////////////////////////////
// Period of 4 time units, reset held for the first 5 cycles
////////////////////////////////////////////////////////////

module tb_clock_gen (
   output logic clk,
   output logic rst
);

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   // Released on a falling edge, away from the sampling edge
   initial begin
      rst = 1'b1;
      repeat (5) @(posedge clk);
      @(negedge clk);
      rst = 1'b0;
   end

endmodule

// File: tb/tb_driver_top.sv
////////////////////////////////////////////////////////////
// Inputs change on the falling edge and outputs are read at the rising edge
// The generator model answers reads one cycle after acceptance
////////////////////////////////////////////////////////////

module tb_driver_top;

   import tg_seq_pkg::*;

   localparam int NUM_LOOPS      = 2;
   localparam int BLOCK_LEN      = 16;
   localparam int ADDR_W         = 10;
   localparam int DATA_W         = 32;
   localparam int WAIT_LIMIT     = 2000;
   localparam int COMPLETE_DELAY = 8;

   logic              clk;
   logic              rst;
   logic              ctrl_ready;
   logic              restart_default_traffic;
   logic              tg_test_complete;
   logic              timeout;
   logic [ADDR_W-1:0] user_address;
   logic [DATA_W-1:0] user_writedata;
   logic              user_write;
   logic              user_read;
   logic              user_waitrequest;
   logic [DATA_W-1:0] user_readdata;
   logic              user_readdatavalid;
   logic [ADDR_W-1:0] cfg_address;
   logic [DATA_W-1:0] cfg_writedata;
   logic              cfg_write;
   logic              cfg_read;
   logic              cfg_waitrequest;
   logic [DATA_W-1:0] cfg_readdata;
   logic              cfg_readdatavalid;
   logic              rst_config;
   logic              user_cfg_start;
   logic              at_default_stage;
   logic              at_wait_user_stage;
   logic              at_done_stage;

   // Generator model state
   logic [31:0]       rand_state;
   logic              backpressure_on;
   logic              complete_on;
   int                complete_cnt;
   logic              rd_pending;
   logic [ADDR_W-1:0] rd_addr;
   logic [ADDR_W-1:0] addr_log[$];
   logic [DATA_W-1:0] data_log[$];

   tb_clock_gen u_clock_gen (
      .clk (clk),
      .rst (rst)
   );

   tg_driver_top #(
      .NUM_LOOPS  (NUM_LOOPS),
      .BLOCK_LEN  (BLOCK_LEN),
      .CFG_ADDR_W (ADDR_W),
      .CFG_DATA_W (DATA_W)
   ) dut (
      .clk                     (clk),
      .rst                     (rst),
      .ctrl_ready              (ctrl_ready),
      .restart_default_traffic (restart_default_traffic),
      .tg_test_complete        (tg_test_complete),
      .timeout                 (timeout),
      .user_address            (user_address),
      .user_writedata          (user_writedata),
      .user_write              (user_write),
      .user_read               (user_read),
      .user_waitrequest        (user_waitrequest),
      .user_readdata           (user_readdata),
      .user_readdatavalid      (user_readdatavalid),
      .cfg_address             (cfg_address),
      .cfg_writedata           (cfg_writedata),
      .cfg_write               (cfg_write),
      .cfg_read                (cfg_read),
      .cfg_waitrequest         (cfg_waitrequest),
      .cfg_readdata            (cfg_readdata),
      .cfg_readdatavalid       (cfg_readdatavalid),
      .rst_config              (rst_config),
      .user_cfg_start          (user_cfg_start),
      .at_default_stage        (at_default_stage),
      .at_wait_user_stage      (at_wait_user_stage),
      .at_done_stage           (at_done_stage)
   );

   function automatic logic [31:0] next_random(input logic [31:0] x);
      logic [31:0] y;
      y = x ^ (x << 13);
      y = y ^ (y >> 17);
      y = y ^ (y << 5);
      return y;
   endfunction

   ////////////////////////////////////////////////////////////
   // Generator model
   ////////////////////////////////////////////////////////////

   // Accepted accesses are taken at the rising edge
   always @(posedge clk) begin
      rd_pending = 1'b0;
      if (!rst) begin
         if (cfg_read && !cfg_waitrequest) begin
            rd_pending = 1'b1;
            rd_addr    = cfg_address;
         end
         if (complete_cnt > 0) begin
            complete_cnt--;
         end
         if (cfg_write && !cfg_waitrequest) begin
            addr_log.push_back(cfg_address);
            data_log.push_back(cfg_writedata);
            if ((cfg_address == ADDR_W'(REG_START)) && (cfg_writedata == 1)) begin
               complete_cnt = COMPLETE_DELAY;
            end
         end
      end
   end

   // Responses change on the falling edge
   always @(negedge clk) begin
      rand_state        = next_random(rand_state);
      cfg_waitrequest   = backpressure_on && rand_state[0];
      tg_test_complete  = complete_on && (complete_cnt == 1);
      cfg_readdatavalid = rd_pending;
      cfg_readdata      = rd_pending ? (DATA_W'(rd_addr) + 32'h100) : '0;
   end

   ////////////////////////////////////////////////////////////
   // Helpers
   ////////////////////////////////////////////////////////////

   task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp) begin
         $display("error at time %0t: %s is %0h, expected %0h", $time, name, got, exp);
         $display("test failed");
         $fatal(1);
      end
   endtask

   task automatic give_up(input string what);
      $display("timeout at time %0t: %s", $time, what);
      $display("test failed");
      $fatal(1);
   endtask

   // Model settings change right after a rising edge
   task automatic set_model(input logic bp, input logic cmpl);
      @(posedge clk);
      backpressure_on = bp;
      complete_on     = cmpl;
   endtask

   task automatic pulse_restart();
      @(negedge clk);
      addr_log.delete();
      data_log.delete();
      restart_default_traffic = 1'b1;
      @(negedge clk);
      restart_default_traffic = 1'b0;
   endtask

   task automatic release_user();
      @(negedge clk);
      user_write = 1'b0;
      user_read  = 1'b0;
   endtask

   // Returns at the rising edge that accepts the write with the strobe still high
   task automatic write_user_reg(input int unsigned addr, input logic [31:0] data);
      int cycles;
      @(negedge clk);
      user_address   = ADDR_W'(addr);
      user_writedata = data;
      user_write     = 1'b1;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) give_up("user write was never accepted");
      end while (user_waitrequest);
   endtask

   task automatic read_user_reg(input int unsigned addr, output logic [31:0] data);
      int cycles;
      @(negedge clk);
      user_address = ADDR_W'(addr);
      user_read    = 1'b1;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) give_up("user read was never accepted");
      end while (user_waitrequest);
      compare("cfg_read", cfg_read, 1);
      compare("cfg_address", cfg_address, addr);
      release_user();
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) give_up("user_readdatavalid never came");
      end while (!user_readdatavalid);
      data = user_readdata;
   endtask

   // One-cycle config reset followed by the wait-user state
   task automatic finish_pattern();
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) give_up("rst_config never went high");
      end while (!rst_config);
      @(posedge clk);
      compare("rst_config", rst_config, 0);
      compare("at_wait_user_stage", at_wait_user_stage, 1);
   endtask

   task automatic check_log(input int passes, input logic block_too);
      logic [31:0] exp_addr[$];
      logic [31:0] exp_data[$];
      for (int p = 0; p < passes; p++) begin
         // Loop count, burst length, then start
         exp_addr.push_back(REG_LOOP_COUNT);
         exp_data.push_back(1);
         exp_addr.push_back(REG_BURST_LENGTH);
         exp_data.push_back(1);
         exp_addr.push_back(REG_START);
         exp_data.push_back(1);
         if (block_too) begin
            exp_addr.push_back(REG_LOOP_COUNT);
            exp_data.push_back(1);
            exp_addr.push_back(REG_BURST_LENGTH);
            exp_data.push_back(BLOCK_LEN);
            exp_addr.push_back(REG_START);
            exp_data.push_back(1);
         end
      end
      compare("number of cfg writes", addr_log.size(), exp_addr.size());
      for (int i = 0; i < exp_addr.size(); i++) begin
         compare("cfg_address", addr_log[i], exp_addr[i]);
         compare("cfg_writedata", data_log[i], exp_data[i]);
      end
   endtask

   ////////////////////////////////////////////////////////////
   // Tests
   ////////////////////////////////////////////////////////////

   task automatic reset_state();
      int cycles;
      cycles = 0;
      do begin
         @(posedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) give_up("reset was never released");
      end while (rst);
      compare("cfg_write", cfg_write, 0);
      compare("cfg_read", cfg_read, 0);
      compare("rst_config", rst_config, 0);
      compare("user_cfg_start", user_cfg_start, 0);
      compare("user_readdatavalid", user_readdatavalid, 0);
      compare("user_waitrequest", user_waitrequest, 1);
      compare("at_default_stage", at_default_stage, 1);
   endtask

   task automatic default_pattern();
      set_model(1'b1, 1'b1);
      @(negedge clk);
      addr_log.delete();
      data_log.delete();
      ctrl_ready = 1'b1;
      finish_pattern();
      check_log(NUM_LOOPS, 1'b1);
   endtask

   task automatic user_passthrough();
      logic [31:0] rdata;
      // The user port does not see cfg_waitrequest
      set_model(1'b0, 1'b1);
      write_user_reg(REG_BURST_LENGTH, 32'h0000_0040);
      compare("cfg_write", cfg_write, 1);
      compare("cfg_address", cfg_address, REG_BURST_LENGTH);
      compare("cfg_writedata", cfg_writedata, 32'h0000_0040);
      release_user();
      compare("logged cfg_address", addr_log[$], REG_BURST_LENGTH);
      compare("logged cfg_writedata", data_log[$], 32'h0000_0040);
      read_user_reg(REG_BURST_LENGTH, rdata);
      compare("user_readdata", rdata, REG_BURST_LENGTH + 32'h100);
   endtask

   task automatic user_test_run();
      logic [31:0] rdata;
      int          cycles;
      write_user_reg(REG_START, 1);
      compare("user_cfg_start", user_cfg_start, 1);
      compare("cfg_write", cfg_write, 1);
      compare("at_wait_user_stage", at_wait_user_stage, 0);
      release_user();
      @(posedge clk);
      compare("user_cfg_start", user_cfg_start, 0);
      // Reads still pass while the test runs
      read_user_reg(REG_LOOP_COUNT, rdata);
      compare("user_readdata", rdata, REG_LOOP_COUNT + 32'h100);
      @(negedge clk);
      user_address   = ADDR_W'(REG_LOOP_COUNT);
      user_writedata = 32'd5;
      user_write     = 1'b1;
      cycles = 0;
      forever begin
         @(posedge clk);
         if (tg_test_complete) break;
         compare("user_waitrequest", user_waitrequest, 1);
         compare("cfg_write", cfg_write, 0);
         compare("at_default_stage", at_default_stage, 0);
         cycles++;
         if (cycles > WAIT_LIMIT) give_up("tg_test_complete never came in the user test");
      end
      compare("stalled write cycles seen", cycles > 0, 1);
      // Stalled write goes through once the stage is done
      @(posedge clk);
      compare("user_waitrequest", user_waitrequest, 0);
      compare("cfg_write", cfg_write, 1);
      compare("at_done_stage", at_done_stage, 1);
      release_user();
   endtask

   task automatic restart_and_timeout();
      int cycles;
      set_model(1'b1, 1'b1);
      pulse_restart();
      finish_pattern();
      check_log(NUM_LOOPS, 1'b1);
      // Generator never completes and the single stage times out
      set_model(1'b1, 1'b0);
      pulse_restart();
      cycles = 0;
      while (addr_log.size() < 3) begin
         @(negedge clk);
         cycles++;
         if (cycles > WAIT_LIMIT) give_up("single stage writes never reached the generator");
      end
      timeout = 1'b1;
      @(negedge clk);
      timeout = 1'b0;
      finish_pattern();
      check_log(1, 1'b0);
   endtask

   initial begin
      ctrl_ready              = 1'b0;
      restart_default_traffic = 1'b0;
      tg_test_complete        = 1'b0;
      timeout                 = 1'b0;
      user_address            = '0;
      user_writedata          = '0;
      user_write              = 1'b0;
      user_read               = 1'b0;
      cfg_waitrequest         = 1'b0;
      cfg_readdata            = '0;
      cfg_readdatavalid       = 1'b0;
      rand_state              = 32'h0f09_93be;
      backpressure_on         = 1'b0;
      complete_on             = 1'b1;
      complete_cnt            = 0;
      rd_pending              = 1'b0;
      rd_addr                 = '0;

      reset_state();
      default_pattern();
      user_passthrough();
      user_test_run();
      restart_and_timeout();

      $display("test passed");
      $finish;
   end

endmodule
